// File: Makefile
TOP = tb_led_matrix

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing -f tb.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

// File: framebuffer_fetch.sv
`timescale 1ns/1ps

module framebuffer_fetch #(
	parameter int fetch_cycles = 4
) (
	input  logic                                   clk_in,
	input  logic                                   reset,
	input  logic [led_matrix_pkg::column_bits-1:0] column_address,
	input  logic [led_matrix_pkg::row_bits-1:0]    row_address,
	input  logic                                   pixel_load_start,
	input  logic [led_matrix_pkg::pixel_bits-1:0]  ram_data,
	output logic [led_matrix_pkg::ram_addr_bits-1:0] ram_address,
	output logic [led_matrix_pkg::pixel_bits-1:0]  rgb565_top,
	output logic [led_matrix_pkg::pixel_bits-1:0]  rgb565_bottom
);

	// phases after the start cycle, the last one lands on count 0
	localparam logic [1:0] load_value = 2'(fetch_cycles - 2);

	logic [1:0] pixel_load_counter;
	logic       pixel_load_running;
	logic       half_address;

	// columns are stored mirrored, so the scan reads 63 - c
	assign ram_address = {half_address, row_address, ~column_address};

	timeout #(
		.counter_width(2)
	) timeout_pixel_load (
		.clk_in (clk_in),
		.reset  (reset),
		.start  (pixel_load_start),
		.value  (load_value),
		.counter(pixel_load_counter),
		.running(pixel_load_running)
	);

	always_ff @(posedge clk_in) begin
		if (reset) begin
			half_address  <= 1'b0;
			rgb565_top    <= '0;
			rgb565_bottom <= '0;
		end else if (pixel_load_start) begin
			// short fetch reads the top half during the start cycle itself,
			// so the bottom address has to follow right away
			half_address <= (fetch_cycles == 3);
		end else if (pixel_load_running) begin
			if (fetch_cycles == 3) begin
				// count 1 takes the top word and parks on the top half again
				// count 0 takes the bottom word
				if (pixel_load_counter == 2'd1) begin
					rgb565_top   <= ram_data;
					half_address <= 1'b0;
				end else if (pixel_load_counter == 2'd0) begin
					rgb565_bottom <= ram_data;
				end
			end else begin
				// count 2 has the top address out, move to the bottom half
				// count 1 has the top word back
				// count 0 has the bottom word back
				if (pixel_load_counter == 2'd2) begin
					half_address <= 1'b1;
				end else if (pixel_load_counter == 2'd1) begin
					rgb565_top <= ram_data;
				end else if (pixel_load_counter == 2'd0) begin
					rgb565_bottom <= ram_data;
				end
			end
		end
	end

endmodule

// File: framebuffer_ram.sv
`timescale 1ns/1ps

module framebuffer_ram (
	input  logic                                  clk_in,
	input  logic                                  we,
	input  logic [led_matrix_pkg::ram_addr_bits-1:0] waddr,
	input  logic [led_matrix_pkg::pixel_bits-1:0]    wdata,
	input  logic [led_matrix_pkg::ram_addr_bits-1:0] raddr,
	output logic [led_matrix_pkg::pixel_bits-1:0]    rdata
);

	localparam int depth = 2 ** led_matrix_pkg::ram_addr_bits;

	// both panel halves, 2048 words
	logic [led_matrix_pkg::pixel_bits-1:0] mem [0:depth-1];

	// host side write port
	always_ff @(posedge clk_in) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// scan side read port, data shows up the cycle after the address
	always_ff @(posedge clk_in) begin
		rdata <= mem[raddr];
	end

endmodule

// File: led_matrix_pkg.sv
package led_matrix_pkg;

	// panel geometry, 64 columns by 16 rows per half
	localparam int column_bits = 6;
	localparam int row_bits = 4;

	// framebuffer word address is {half, row, column}
	localparam int ram_addr_bits = 1 + row_bits + column_bits;

	// one RGB565 pixel per framebuffer word
	localparam int pixel_bits = 16;

	// wishbone word address, top bit clear selects the pixel window
	localparam int wb_addr_bits = 12;

	// control register, bit 0 enables the scan
	localparam logic [wb_addr_bits-1:0] ctrl_addr = 12'h800;

	// status register, read only, frame count
	localparam logic [wb_addr_bits-1:0] status_addr = 12'h801;

endpackage

// File: led_matrix_stimulus.txt
# P addr data: pixel write, C value: control write, R addr expected: read and compare
# W rows: wait for that many latches (decimal), E: end, all other numbers hex
P 000 f800
P 03f 07e0
P 400 001f
P 7ff ffff
P 1a5 1234
R 000 0000
R 5a5 0000
R 801 0000
R 800 0000
C 1
R 800 0001
W 16
R 801 0001
P 040 abcd
P 47f 5555
W 8
P 123 c0de
W 32
R 801 0003
C 0
R 801 0003
R 800 0000
R 3ff 0000
C 1
W 16
R 801 0004
C 0
E

// File: led_matrix_top.sv
`timescale 1ns/1ps

module led_matrix_top #(
	parameter int fetch_cycles = 4
) (
	input  logic                                    clk_in,
	input  logic                                    reset,
	input  logic                                    wb_cyc,
	input  logic                                    wb_stb,
	input  logic                                    wb_we,
	input  logic [led_matrix_pkg::wb_addr_bits-1:0] wb_adr,
	input  logic [led_matrix_pkg::pixel_bits-1:0]   wb_dat_w,
	output logic [led_matrix_pkg::pixel_bits-1:0]   wb_dat_r,
	output logic                                    wb_ack,
	output logic [led_matrix_pkg::pixel_bits-1:0]   rgb565_top,
	output logic [led_matrix_pkg::pixel_bits-1:0]   rgb565_bottom,
	output logic                                    shift_strobe,
	output logic                                    latch,
	output logic                                    blank,
	output logic [led_matrix_pkg::row_bits-1:0]     row_out
);

	// host write path
	logic                                     ram_we;
	logic [led_matrix_pkg::ram_addr_bits-1:0] ram_waddr;
	logic [led_matrix_pkg::pixel_bits-1:0]    ram_wdata;

	// scan read path
	logic [led_matrix_pkg::ram_addr_bits-1:0] ram_address;
	logic [led_matrix_pkg::pixel_bits-1:0]    ram_data;
	logic [led_matrix_pkg::column_bits-1:0]   column_address;
	logic [led_matrix_pkg::row_bits-1:0]      row_address;
	logic                                     pixel_load_start;

	// control between registers and scan
	logic enable;
	logic frame_done;

	matrix_regs i_matrix_regs (
		.clk_in    (clk_in),
		.reset     (reset),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.ram_we    (ram_we),
		.ram_waddr (ram_waddr),
		.ram_wdata (ram_wdata),
		.enable    (enable),
		.frame_done(frame_done)
	);

	framebuffer_ram i_framebuffer_ram (
		.clk_in(clk_in),
		.we    (ram_we),
		.waddr (ram_waddr),
		.wdata (ram_wdata),
		.raddr (ram_address),
		.rdata (ram_data)
	);

	framebuffer_fetch #(
		.fetch_cycles(fetch_cycles)
	) i_framebuffer_fetch (
		.clk_in          (clk_in),
		.reset           (reset),
		.column_address  (column_address),
		.row_address     (row_address),
		.pixel_load_start(pixel_load_start),
		.ram_data        (ram_data),
		.ram_address     (ram_address),
		.rgb565_top      (rgb565_top),
		.rgb565_bottom   (rgb565_bottom)
	);

	matrix_scan #(
		.fetch_cycles(fetch_cycles)
	) i_matrix_scan (
		.clk_in          (clk_in),
		.reset           (reset),
		.enable          (enable),
		.column_address  (column_address),
		.row_address     (row_address),
		.pixel_load_start(pixel_load_start),
		.shift_strobe    (shift_strobe),
		.latch           (latch),
		.blank           (blank),
		.row_out         (row_out),
		.frame_done      (frame_done)
	);

endmodule

// File: matrix_regs.sv
`timescale 1ns/1ps

module matrix_regs (
	input  logic                                     clk_in,
	input  logic                                     reset,
	input  logic                                     wb_cyc,
	input  logic                                     wb_stb,
	input  logic                                     wb_we,
	input  logic [led_matrix_pkg::wb_addr_bits-1:0]  wb_adr,
	input  logic [led_matrix_pkg::pixel_bits-1:0]    wb_dat_w,
	output logic [led_matrix_pkg::pixel_bits-1:0]    wb_dat_r,
	output logic                                     wb_ack,
	output logic                                     ram_we,
	output logic [led_matrix_pkg::ram_addr_bits-1:0] ram_waddr,
	output logic [led_matrix_pkg::pixel_bits-1:0]    ram_wdata,
	output logic                                     enable,
	input  logic                                     frame_done
);

	logic                                  request;
	logic                                  pixel_window;
	logic [led_matrix_pkg::pixel_bits-1:0] frame_count;

	// no new request in the ack cycle, so a held strobe gives one ack
	assign request = wb_cyc && wb_stb && !wb_ack;

	// lower half of the address space maps straight onto the framebuffer
	assign pixel_window = !wb_adr[led_matrix_pkg::wb_addr_bits-1];

	// control state and bus handshake
	always_ff @(posedge clk_in) begin
		if (reset) begin
			wb_ack      <= 1'b0;
			ram_we      <= 1'b0;
			enable      <= 1'b0;
			frame_count <= '0;
		end else begin
			wb_ack <= request;
			// framebuffer write goes out together with the ack
			ram_we <= request && wb_we && pixel_window;
			if (request && wb_we && (wb_adr == led_matrix_pkg::ctrl_addr)) begin
				enable <= wb_dat_w[0];
			end
			// wraps at 16 bits
			if (frame_done) begin
				frame_count <= frame_count + 1'b1;
			end
		end
	end

	// write payload and read data
	always_ff @(posedge clk_in) begin
		if (request) begin
			ram_waddr <= wb_adr[led_matrix_pkg::ram_addr_bits-1:0];
			ram_wdata <= wb_dat_w;
			if (wb_adr == led_matrix_pkg::ctrl_addr) begin
				wb_dat_r <= {{(led_matrix_pkg::pixel_bits-1){1'b0}}, enable};
			end else if (wb_adr == led_matrix_pkg::status_addr) begin
				wb_dat_r <= frame_count;
			end else begin
				// pixel window is write only, unmapped space reads zero too
				wb_dat_r <= '0;
			end
		end
	end

endmodule

// File: matrix_scan.sv
`timescale 1ns/1ps

module matrix_scan #(
	parameter int fetch_cycles = 4
) (
	input  logic                                   clk_in,
	input  logic                                   reset,
	input  logic                                   enable,
	output logic [led_matrix_pkg::column_bits-1:0] column_address,
	output logic [led_matrix_pkg::row_bits-1:0]    row_address,
	output logic                                   pixel_load_start,
	output logic                                   shift_strobe,
	output logic                                   latch,
	output logic                                   blank,
	output logic [led_matrix_pkg::row_bits-1:0]    row_out,
	output logic                                   frame_done
);

	// one column takes fetch_cycles + 1 cycles, phase 0 .. fetch_cycles
	localparam int phase_bits = $clog2(fetch_cycles + 1);
	localparam logic [phase_bits-1:0] last_phase = phase_bits'(fetch_cycles);

	logic                  active;
	logic                  latch_cycle;
	logic [phase_bits-1:0] phase;

	// fetch kicks off at phase 0, the fetched pair is shifted at the last phase
	assign pixel_load_start = active && !latch_cycle && (phase == '0);
	assign shift_strobe     = active && !latch_cycle && (phase == last_phase);
	assign latch            = latch_cycle;

	// last row of the frame finishes with this latch
	assign frame_done = latch_cycle && (row_address == '1);

	// panel stays dark while the scan is stopped
	assign blank = !active;

	always_ff @(posedge clk_in) begin
		if (reset) begin
			active         <= 1'b0;
			latch_cycle    <= 1'b0;
			phase          <= '0;
			column_address <= '0;
			row_address    <= '0;
			row_out        <= '0;
		end else begin
			latch_cycle <= 1'b0;
			if (!active) begin
				// idle, wait for enable with the counters at the frame start
				phase          <= '0;
				column_address <= '0;
				row_address    <= '0;
				if (enable) begin
					active <= 1'b1;
				end
			end else if (latch_cycle) begin
				// row boundary, only place where the scan may stop
				row_address <= row_address + 1'b1;
				phase       <= '0;
				if (!enable) begin
					active <= 1'b0;
				end
			end else if (phase == last_phase) begin
				phase          <= '0;
				column_address <= column_address + 1'b1;
				if (column_address == '1) begin
					// 64th column shifted, latch next cycle
					latch_cycle <= 1'b1;
					row_out     <= row_address;
				end
			end else begin
				phase <= phase + 1'b1;
			end
		end
	end

endmodule

// File: tb.f
led_matrix_pkg.sv
timeout.sv
framebuffer_ram.sv
framebuffer_fetch.sv
matrix_scan.sv
matrix_regs.sv
led_matrix_top.sv
tb_led_matrix.sv

// File: tb_led_matrix.sv
`timescale 1ns/1ps

module tb_led_matrix;

	localparam int fetch_cycles = 4;
	// one full row of 64 columns plus the latch cycle
	localparam int row_cycles = 64 * (fetch_cycles + 1) + 1;
	localparam int ack_timeout = 20;

	logic        clk_in = 1'b0;
	logic        reset;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [11:0] wb_adr;
	logic [15:0] wb_dat_w;
	logic [15:0] wb_dat_r;
	logic        wb_ack;
	logic [15:0] rgb565_top;
	logic [15:0] rgb565_bottom;
	logic        shift_strobe;
	logic        latch;
	logic        blank;
	logic [3:0]  row_out;

	// shadow framebuffer, {half, row, column} like the RAM
	logic [15:0] shadow [0:2047];
	// value before a write made while the scan ran, and the frame of that write
	logic [15:0] old_word [0:2047];
	int          pend_frame [0:2047];

	// scan model state, only touched by the monitor on the falling edge
	int          col_count = 0;
	int          row_count = 0;
	int          rows_done = 0;
	int          frame_count = 0;
	logic [10:0] top_idx;
	logic [10:0] bot_idx;

	bit          scan_enabled = 1'b0;

	always #5 clk_in = ~clk_in;

	led_matrix_top #(
		.fetch_cycles(fetch_cycles)
	) i_led_matrix_top (
		.clk_in       (clk_in),
		.reset        (reset),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_w     (wb_dat_w),
		.wb_dat_r     (wb_dat_r),
		.wb_ack       (wb_ack),
		.rgb565_top   (rgb565_top),
		.rgb565_bottom(rgb565_bottom),
		.shift_strobe (shift_strobe),
		.latch        (latch),
		.blank        (blank),
		.row_out      (row_out)
	);

	task automatic stop_with_error(input string what);
		$display("%s at %0t", what, $time);
		$display("Checks failed");
		$fatal(1, "stopping on the first error");
	endtask

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (actual !== expected) begin
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
			$display("Checks failed");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// a word rewritten during the current frame may still show its old value
	function automatic logic [15:0] expected_word(input logic [10:0] idx,
			input logic [15:0] seen);
		if (pend_frame[idx] == frame_count && seen == old_word[idx]) begin
			return old_word[idx];
		end
		return shadow[idx];
	endfunction

	// one classic cycle, request held until ack, then exactly one ack
	task automatic wb_access(input logic we, input logic [11:0] adr,
			input logic [15:0] dat, output logic [15:0] rdat);
		int          n;
		logic [10:0] idx;
		n = 0;
		idx = adr[10:0];
		@(posedge clk_in);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= dat;
		do begin
			@(negedge clk_in);
			n++;
			if (!wb_ack && n > ack_timeout) begin
				stop_with_error("no wishbone ack within the timeout");
			end
		end while (!wb_ack);
		rdat = wb_dat_r;
		@(posedge clk_in);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		// RAM takes the word on this edge
		if (we && !adr[11]) begin
			if (scan_enabled) begin
				old_word[idx]   = shadow[idx];
				pend_frame[idx] = frame_count;
			end
			shadow[idx] = dat;
		end
		@(negedge clk_in);
		check_value("wb_ack", 16'd0, 16'(wb_ack));
	endtask

	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge clk_in);
			check_value("blank", 16'd1, 16'(blank));
			check_value("shift_strobe", 16'd0, 16'(shift_strobe));
			check_value("latch", 16'd0, 16'(latch));
		end
	endtask

	task automatic wait_blank();
		int n;
		n = 0;
		do begin
			@(negedge clk_in);
			n++;
			if (!blank && n > row_cycles + 8) begin
				stop_with_error("scan did not stop within one row");
			end
		end while (!blank);
	endtask

	task automatic wait_rows(input int rows);
		int target;
		int last;
		int idle;
		@(posedge clk_in);
		target = rows_done + rows;
		last = rows_done;
		idle = 0;
		while (rows_done < target) begin
			@(posedge clk_in);
			if (rows_done != last) begin
				last = rows_done;
				idle = 0;
			end else begin
				idle++;
			end
			if (idle > 2 * row_cycles) begin
				stop_with_error("no latch within two rows while waiting for rows");
			end
		end
	endtask

	// reference scan model, column c of row r shows stored column 63 - c
	always @(negedge clk_in) begin
		if (reset || blank) begin
			col_count = 0;
			row_count = 0;
		end else begin
			if (shift_strobe) begin
				if (col_count == 64) begin
					stop_with_error("65th shift strobe in a row without a latch");
				end
				top_idx = {1'b0, 4'(row_count), 6'(63 - col_count)};
				bot_idx = {1'b1, 4'(row_count), 6'(63 - col_count)};
				check_value("rgb565_top", expected_word(top_idx, rgb565_top), rgb565_top);
				check_value("rgb565_bottom", expected_word(bot_idx, rgb565_bottom),
					rgb565_bottom);
				col_count++;
			end
			if (latch) begin
				check_value("strobes per row", 16'd64, 16'(col_count));
				check_value("row_out", 16'(row_count), 16'(row_out));
				if (row_count == 15) begin
					frame_count++;
				end
				row_count = (row_count + 1) % 16;
				col_count = 0;
				rows_done++;
			end
		end
	end

	initial begin
		int                 fd;
		int                 code;
		int                 rows;
		bit                 done;
		logic [7:0]         cmd;
		logic [11:0]        adr;
		logic [15:0]        dat;
		logic [15:0]        rdat;
		logic [31:0]        lcg_state;
		logic [8*128-1:0]   line;
		reset    = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		for (int i = 0; i < 2048; i++) begin
			pend_frame[i] = -1;
		end
		repeat (10) @(posedge clk_in);
		reset <= 1'b0;

		// idle panel straight after reset
		@(negedge clk_in);
		check_value("rgb565_top", 16'd0, rgb565_top);
		check_value("rgb565_bottom", 16'd0, rgb565_bottom);
		check_value("wb_ack", 16'd0, 16'(wb_ack));
		expect_quiet(200);

		// whole framebuffer gets pseudo random words first
		lcg_state = 32'd21013;
		for (int i = 0; i < 2048; i++) begin
			lcg_state = lcg_next(lcg_state);
			wb_access(1'b1, 12'(i), lcg_state[31:16], rdat);
		end

		fd = $fopen("led_matrix_stimulus.txt", "r");
		if (fd == 0) begin
			stop_with_error("cannot open led_matrix_stimulus.txt");
		end
		done = 1'b0;
		while (!done) begin
			code = $fscanf(fd, " %c", cmd);
			if (code != 1) begin
				stop_with_error("stimulus file ended without an end mark");
			end
			case (cmd)
				"#": code = $fgets(line, fd);
				"P": begin
					code = $fscanf(fd, "%h %h", adr, dat);
					wb_access(1'b1, adr, dat, rdat);
				end
				"C": begin
					code = $fscanf(fd, "%h", dat);
					wb_access(1'b1, led_matrix_pkg::ctrl_addr, dat, rdat);
					if (dat[0]) begin
						scan_enabled = 1'b1;
					end else begin
						// stops at the next row boundary
						wait_blank();
						expect_quiet(200);
						scan_enabled = 1'b0;
					end
				end
				"R": begin
					code = $fscanf(fd, "%h %h", adr, dat);
					wb_access(1'b0, adr, 16'd0, rdat);
					check_value("wb_dat_r", dat, rdat);
				end
				"W": begin
					code = $fscanf(fd, "%d", rows);
					wait_rows(rows);
				end
				"E": done = 1'b1;
				default: stop_with_error("unknown command in the stimulus file");
			endcase
		end
		$fclose(fd);

		$display("All checks passed");
		$finish;
	end

endmodule

// File: timeout.sv
`timescale 1ns/1ps

module timeout #(
	parameter int counter_width = 2
) (
	input  logic                     clk_in,
	input  logic                     reset,
	input  logic                     start,
	input  logic [counter_width-1:0] value,
	output logic [counter_width-1:0] counter,
	output logic                     running
);

	// counter walks value, value-1, ... 0 with running high the whole way
	always_ff @(posedge clk_in) begin
		if (reset) begin
			counter <= '0;
			running <= 1'b0;
		end else if (start) begin
			// a start always reloads, even mid count
			counter <= value;
			running <= 1'b1;
		end else if (running) begin
			if (counter == '0) begin
				// the zero phase has had its cycle, stop here
				running <= 1'b0;
			end else begin
				counter <= counter - 1'b1;
			end
		end
	end

endmodule
